/* logic/kulisch_defs.svh */
`ifndef KULISCH_DEFS_SVH
`define KULISCH_DEFS_SVH

// Integer and fraction bits of the Kulisch accumulator word
`define ACC_NON_FRAC 16
`define ACC_FRAC 16

// The accumulator is a plain two's complement word of both parts together
`define ACC_WIDTH (`ACC_NON_FRAC + `ACC_FRAC)

// Operands are Q4.4 signed fixed point
`define OPERAND_WIDTH 8
`define OPERAND_FRAC 4

// Set to zero to remove the overflow tracking logic from the adder
`define OVERFLOW_DETECTION 1

// This operand encoding stands for infinity rather than a number
`define INF_PATTERN 8'h80

// Width of the Wishbone data bus
`define BUS_WIDTH 32

`endif

/* logic/kulischPkg.sv */
package kulischPkg;

  // Word addresses of the register file as seen from the bus
  typedef enum logic [1:0] {
    // Operand a in the low byte and operand b in the next byte
    REG_OPERAND = 2'd0,
    // Bit 0 written as one clears the sum and every flag
    REG_CONTROL = 2'd1,
    // Raw accumulator bits in Q16.16
    REG_SUM     = 2'd2,
    // Packed flags at the positions below
    REG_STATUS  = 2'd3
  } regAddr_t;

  // Set once an infinity operand has been accumulated
  localparam int STATUS_INF = 0;

  // Sticky flag for a sum that left the accumulator range
  localparam int STATUS_OVERFLOW = 1;

  // Direction of that overflow, one meaning negative
  localparam int STATUS_OVERFLOW_SIGN = 2;

endpackage

/* logic/kulischIf.sv */
`timescale 1ns/1ns
`include "kulisch_defs.svh"

// One Kulisch accumulator word together with its special-state flags
interface kulischIf;

  // The word holds an infinity and the bits carry no meaning
  logic isInf;

  // The true value left the accumulator range at some point
  logic isOverflow;

  // High when that overflow went past the negative limit
  logic overflowSign;

  // Fixed-point value in two's complement
  logic [`ACC_WIDTH-1:0] bits;

  // Consumers of a word
  modport inputIf(input isInf, input isOverflow, input overflowSign, input bits);

  // The block that produces a word
  modport outputIf(output isInf, output isOverflow, output overflowSign, output bits);

endinterface

/* logic/kulischAccumulatorAdd.sv */
`timescale 1ns/1ns
`include "kulisch_defs.svh"

// Adds two accumulator words and carries the overflow state of a ahead of b
module kulischAccumulatorAdd (
  kulischIf.inputIf a,
  kulischIf.inputIf b,
  kulischIf.outputIf out
);

  logic [`ACC_WIDTH-1:0] sumBits;
  logic overflow;
  logic overflowSign;

  // The bits always wrap and the flags record what was lost
  assign sumBits = a.bits + b.bits;

  generate
    if (`OVERFLOW_DETECTION != 0) begin : genOverflow
      logic isNegA;
      logic isNegB;
      logic isNegSum;
      logic sumWraps;
      logic inputsOverflow;

      always_comb begin
        isNegA = a.bits[`ACC_WIDTH-1];
        isNegB = b.bits[`ACC_WIDTH-1];
        isNegSum = sumBits[`ACC_WIDTH-1];

        // Two values of one sign can only leave the range by flipping that sign
        sumWraps = (isNegA == isNegB) && (isNegSum != isNegA);

        // An overflowed input poisons the result no matter what the bits say
        inputsOverflow = a.isOverflow || b.isOverflow;
        overflow = inputsOverflow || sumWraps;

        // The state word arrives on a so its direction is kept first
        if (a.isOverflow) begin
          overflowSign = a.overflowSign;
        end else if (b.isOverflow) begin
          overflowSign = b.overflowSign;
        end else begin
          // A fresh wrap points the way both inputs were heading
          overflowSign = sumWraps && isNegA;
        end
      end
    end else begin : genNoOverflow
      // Without tracking the accumulator simply wraps silently
      assign overflow = 1'b0;
      assign overflowSign = 1'b0;
    end
  endgenerate

  // Infinity on either side wins over any finite value
  assign out.isInf = a.isInf | b.isInf;
  assign out.isOverflow = overflow;
  assign out.overflowSign = overflowSign;
  assign out.bits = sumBits;

endmodule

/* logic/fixedProductToKulisch.sv */
`timescale 1ns/1ns
`include "kulisch_defs.svh"

// Exact product of two Q4.4 operands placed into a Q16.16 accumulator word
module fixedProductToKulisch (
  input  logic [`OPERAND_WIDTH-1:0] opA,
  input  logic [`OPERAND_WIDTH-1:0] opB,
  kulischIf.outputIf out
);

  // A full-width product needs no rounding at all
  localparam int PRODUCT_WIDTH = 2 * `OPERAND_WIDTH;

  // The product has twice the operand fraction bits and must move up to the
  // accumulator's binary point
  localparam int ALIGN_SHIFT = `ACC_FRAC - 2 * `OPERAND_FRAC;

  logic signed [PRODUCT_WIDTH-1:0] product;
  logic [`ACC_WIDTH-1:0] extended;
  logic anyInf;

  // Q8.8 result, which holds even the largest magnitude of -8 times -8
  assign product = $signed(opA) * $signed(opB);

  // Sign extension keeps the value while widening to the accumulator
  assign extended = {{(`ACC_WIDTH - PRODUCT_WIDTH){product[PRODUCT_WIDTH-1]}}, product};

  // The infinity encoding is checked on the raw operands
  assign anyInf = (opA == `INF_PATTERN) || (opB == `INF_PATTERN);

  always_comb begin
    out.isInf = anyInf;

    // The shift only drops sign copies since the product has 8 integer bits
    // and the accumulator has 16
    if (anyInf) begin
      out.bits = '0;
    end else begin
      out.bits = extended << ALIGN_SHIFT;
    end

    // A single product can never leave the accumulator range
    out.isOverflow = 1'b0;
    out.overflowSign = 1'b0;
  end

endmodule

/* logic/kulischAccumulatorUnit.sv */
`timescale 1ns/1ns
`include "kulisch_defs.svh"

// Running sum of operand products held in one Kulisch accumulator register
module kulischAccumulatorUnit (
  input  logic clk,
  input  logic rstN,
  input  logic accumulate,
  input  logic clear,
  input  logic [`OPERAND_WIDTH-1:0] opA,
  input  logic [`OPERAND_WIDTH-1:0] opB,
  output logic [`ACC_WIDTH-1:0] sum,
  output logic isInf,
  output logic isOverflow,
  output logic overflowSign
);

  // Current state, the new product and their sum
  kulischIf accState();
  kulischIf prodWord();
  kulischIf sumWord();

  logic stateInf;
  logic stateOverflow;
  logic stateOverflowSign;
  logic [`ACC_WIDTH-1:0] stateBits;

  fixedProductToKulisch productConv (
    .opA(opA),
    .opB(opB),
    .out(prodWord.outputIf)
  );

  // State goes in as a so its sticky overflow direction survives
  kulischAccumulatorAdd accAdd (
    .a(accState.inputIf),
    .b(prodWord.inputIf),
    .out(sumWord.outputIf)
  );

  // Clear takes priority when both strobes arrive together
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stateInf <= 1'b0;
      stateOverflow <= 1'b0;
      stateOverflowSign <= 1'b0;
      stateBits <= '0;
    end else if (clear) begin
      stateInf <= 1'b0;
      stateOverflow <= 1'b0;
      stateOverflowSign <= 1'b0;
      stateBits <= '0;
    end else if (accumulate) begin
      stateInf <= sumWord.isInf;
      stateOverflow <= sumWord.isOverflow;
      stateOverflowSign <= sumWord.overflowSign;
      stateBits <= sumWord.bits;
    end
  end

  assign accState.isInf = stateInf;
  assign accState.isOverflow = stateOverflow;
  assign accState.overflowSign = stateOverflowSign;
  assign accState.bits = stateBits;

  // The register file reads the state as it stands after the last update
  assign sum = accState.bits;
  assign isInf = accState.isInf;
  assign isOverflow = accState.isOverflow;
  assign overflowSign = accState.overflowSign;

endmodule

/* logic/kulischWishboneSlave.sv */
`timescale 1ns/1ns
`include "kulisch_defs.svh"

// Wishbone classic register file in front of the accumulator unit
module kulischWishboneSlave (
  input  logic clk,
  input  logic rstN,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [1:0] adr,
  input  logic [`BUS_WIDTH-1:0] datIn,
  output logic [`BUS_WIDTH-1:0] datOut,
  output logic ack,
  output logic accumulate,
  output logic clear,
  output logic [`OPERAND_WIDTH-1:0] opA,
  output logic [`OPERAND_WIDTH-1:0] opB,
  input  logic [`ACC_WIDTH-1:0] sum,
  input  logic isInf,
  input  logic isOverflow,
  input  logic overflowSign
);
  import kulischPkg::*;

  regAddr_t addr;
  logic request;
  logic reqSeen;
  logic commit;
  logic waitLow;
  logic [`BUS_WIDTH-1:0] statusWord;
  logic [`BUS_WIDTH-1:0] operandWord;
  logic [`BUS_WIDTH-1:0] readData;

  assign addr = regAddr_t'(adr);
  assign request = cyc && stb;

  // The transfer completes on the edge after the request was first seen,
  // provided the master is still asking
  assign commit = reqSeen && request;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      reqSeen <= 1'b0;
      ack <= 1'b0;
      waitLow <= 1'b0;
      accumulate <= 1'b0;
      clear <= 1'b0;
    end else begin
      // A new request is only taken once stb has dropped after the last one
      reqSeen <= request && !reqSeen && !waitLow;
      ack <= commit;
      if (reqSeen) begin
        waitLow <= 1'b1;
      end else if (!stb) begin
        waitLow <= 1'b0;
      end

      // One-cycle strobes to the unit, which updates on the following edge
      accumulate <= commit && we && (addr == REG_OPERAND);
      clear <= commit && we && (addr == REG_CONTROL) && datIn[0];
    end
  end

  // Operand pair and read data are captured on the edge that completes the transfer
  always_ff @(posedge clk) begin
    if (commit && we && (addr == REG_OPERAND)) begin
      opA <= datIn[`OPERAND_WIDTH-1:0];
      opB <= datIn[2*`OPERAND_WIDTH-1:`OPERAND_WIDTH];
    end
    if (commit) begin
      datOut <= readData;
    end
  end

  always_comb begin
    statusWord = '0;
    statusWord[STATUS_INF] = isInf;
    statusWord[STATUS_OVERFLOW] = isOverflow;
    statusWord[STATUS_OVERFLOW_SIGN] = overflowSign;

    // Operands read back in the same layout they were written
    operandWord = {{(`BUS_WIDTH - 2 * `OPERAND_WIDTH){1'b0}}, opB, opA};

    case (addr)
      REG_OPERAND: readData = operandWord;
      REG_SUM:     readData = sum;
      REG_STATUS:  readData = statusWord;
      // The control register is write-only
      default:     readData = '0;
    endcase
  end

endmodule

/* logic/kulischMacTop.sv */
`timescale 1ns/1ns
`include "kulisch_defs.svh"

// Memory-mapped multiply-accumulate unit on a Wishbone classic slave port
module kulischMacTop (
  input  logic clk,
  input  logic rstN,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [1:0] adr,
  input  logic [`BUS_WIDTH-1:0] datIn,
  output logic [`BUS_WIDTH-1:0] datOut,
  output logic ack
);

  // Strobes and operands from the register file
  logic accumulate;
  logic clear;
  logic [`OPERAND_WIDTH-1:0] opA;
  logic [`OPERAND_WIDTH-1:0] opB;

  // Accumulator state back to the register file
  logic [`ACC_WIDTH-1:0] sum;
  logic isInf;
  logic isOverflow;
  logic overflowSign;

  kulischWishboneSlave busSlave (
    .clk(clk),
    .rstN(rstN),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .datIn(datIn),
    .datOut(datOut),
    .ack(ack),
    .accumulate(accumulate),
    .clear(clear),
    .opA(opA),
    .opB(opB),
    .sum(sum),
    .isInf(isInf),
    .isOverflow(isOverflow),
    .overflowSign(overflowSign)
  );

  kulischAccumulatorUnit accUnit (
    .clk(clk),
    .rstN(rstN),
    .accumulate(accumulate),
    .clear(clear),
    .opA(opA),
    .opB(opB),
    .sum(sum),
    .isInf(isInf),
    .isOverflow(isOverflow),
    .overflowSign(overflowSign)
  );

endmodule

/* testbench/kulischMacTb.sv */
`timescale 1ns/1ns
`include "kulisch_defs.svh"

// Drives the MAC unit over Wishbone and checks every read against a model
module kulischMacTb;
  import kulischPkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_RANDOM = 200;
  // Enough pairs of the largest product to cross either accumulator limit
  localparam int OVERFLOW_PAIRS = 525;
  // Last count of such pairs that still fits since 520 * 63.0039 stays below 32768
  localparam int LIMIT_CHECK_AT = 520;
  localparam int TRANSFER_BUDGET = 2 + 3 * NUM_RANDOM + 2 * (OVERFLOW_PAIRS + 20) + 40;
  localparam int WATCHDOG_CYCLES = TRANSFER_BUDGET * 10 + 200;

  logic clk;
  logic rstN;
  logic cyc;
  logic stb;
  logic we;
  logic [1:0] adr;
  logic [`BUS_WIDTH-1:0] datIn;
  logic [`BUS_WIDTH-1:0] datOut;
  logic ack;

  // Exact running sum and flags of the reference model
  longint modelSum;
  logic modelInf;
  logic modelOverflow;
  logic modelOverflowSign;
  logic [`BUS_WIDTH-1:0] expSum;
  logic [`BUS_WIDTH-1:0] expStatus;
  logic [31:0] lcgState;

  // The read that is currently on the bus
  logic readPending;
  logic [`BUS_WIDTH-1:0] readExpected;
  string readName;
  int readsIssued;
  int readsChecked;
  int checkCount;
  int errorCount;

  kulischMacTop dut (
    .clk(clk),
    .rstN(rstN),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .datIn(datIn),
    .datOut(datOut),
    .ack(ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Ends a run that stalls, sized by the number of bus transfers
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [`BUS_WIDTH-1:0] statusWord(input logic inf, input logic ovf,
                                                       input logic sign);
    logic [`BUS_WIDTH-1:0] word;
    word = '0;
    word[STATUS_INF] = inf;
    word[STATUS_OVERFLOW] = ovf;
    word[STATUS_OVERFLOW_SIGN] = sign;
    return word;
  endfunction

  // Adds one exact product to the model and returns {sign, overflow, inf, bits}
  function automatic logic [`ACC_WIDTH+2:0] modelAccumulate(
    input logic [`OPERAND_WIDTH-1:0] a,
    input logic [`OPERAND_WIDTH-1:0] b
  );
    longint product;
    longint maxAcc;
    longint minAcc;
    maxAcc = (longint'(1) <<< (`ACC_WIDTH - 1)) - 1;
    minAcc = -(longint'(1) <<< (`ACC_WIDTH - 1));
    if (a == `INF_PATTERN || b == `INF_PATTERN) begin
      // An infinity contributes nothing to the bits but sticks until a clear
      modelInf = 1'b1;
    end else begin
      product = longint'($signed(a)) * longint'($signed(b));
      // Q8.8 product scaled up to the Q16.16 binary point
      modelSum = modelSum + product * (longint'(1) <<< (`ACC_FRAC - 2 * `OPERAND_FRAC));
      // Only the first exit from the range sets the direction
      if (!modelOverflow && modelSum > maxAcc) begin
        modelOverflow = 1'b1;
        modelOverflowSign = 1'b0;
      end else if (!modelOverflow && modelSum < minAcc) begin
        modelOverflow = 1'b1;
        modelOverflowSign = 1'b1;
      end
    end
    return {modelOverflowSign, modelOverflow, modelInf, modelSum[`ACC_WIDTH-1:0]};
  endfunction

  // Draws finite operands only and redraws the infinity encoding
  function automatic logic [`OPERAND_WIDTH-1:0] randomOperand();
    logic [`OPERAND_WIDTH-1:0] value;
    value = `INF_PATTERN;
    while (value == `INF_PATTERN) begin
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      value = lcgState[23:16];
    end
    return value;
  endfunction

  task automatic checkValue(input string name, input logic [`BUS_WIDTH-1:0] actual,
                            input logic [`BUS_WIDTH-1:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch %s: got %08h, expected %08h", name, actual, expected);
    end
  endtask

  // Entered and left one nanosecond after a rising edge
  task automatic busTransfer(input logic write, input regAddr_t addr,
                             input logic [`BUS_WIDTH-1:0] data);
    int cycles;
    cyc = 1'b1;
    stb = 1'b1;
    we = write;
    adr = addr;
    datIn = data;
    cycles = 0;
    @(posedge clk);
    #1;
    while (!ack) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    // Ack follows on the edge after the one that saw the request
    checkValue("ack delay", cycles, 1);
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    // The slave wants stb low over one edge before the next request
    @(posedge clk);
    #1;
    // Ack lasts exactly one cycle
    checkValue("ack", ack, 1'b0);
  endtask

  task automatic busRead(input regAddr_t addr, input logic [`BUS_WIDTH-1:0] expected,
                         input string name);
    readExpected = expected;
    readName = name;
    readPending = 1'b1;
    readsIssued++;
    busTransfer(1'b0, addr, '0);
    readPending = 1'b0;
  endtask

  // Read data is compared on the edge that ends the ack cycle
  always @(posedge clk) begin
    if (readPending && ack) begin
      readsChecked++;
      checkValue(readName, datOut, readExpected);
    end
  end

  task automatic accumulatePair(input logic [`OPERAND_WIDTH-1:0] a,
                                input logic [`OPERAND_WIDTH-1:0] b);
    logic [`ACC_WIDTH+2:0] result;
    result = modelAccumulate(a, b);
    expSum = result[`ACC_WIDTH-1:0];
    expStatus = statusWord(result[`ACC_WIDTH], result[`ACC_WIDTH+1], result[`ACC_WIDTH+2]);
    busTransfer(1'b1, REG_OPERAND, {{(`BUS_WIDTH - 2 * `OPERAND_WIDTH){1'b0}}, b, a});
  endtask

  task automatic checkState();
    busRead(REG_SUM, expSum, "sum");
    busRead(REG_STATUS, expStatus, "status");
  endtask

  task automatic clearAll();
    busTransfer(1'b1, REG_CONTROL, 32'h1);
    modelSum = 0;
    modelInf = 1'b0;
    modelOverflow = 1'b0;
    modelOverflowSign = 1'b0;
    expSum = '0;
    expStatus = '0;
  endtask

  task automatic randomPairs(input int count);
    logic [`OPERAND_WIDTH-1:0] a;
    logic [`OPERAND_WIDTH-1:0] b;
    repeat (count) begin
      a = randomOperand();
      b = randomOperand();
      accumulatePair(a, b);
      checkState();
    end
  endtask

  initial begin
    rstN = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    datIn = '0;
    readPending = 1'b0;
    readExpected = '0;
    readsIssued = 0;
    readsChecked = 0;
    checkCount = 0;
    errorCount = 0;
    modelSum = 0;
    modelInf = 1'b0;
    modelOverflow = 1'b0;
    modelOverflowSign = 1'b0;
    expSum = '0;
    expStatus = '0;
    lcgState = 32'hd1c1;
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Reset state, then random products of both signs
    checkState();
    randomPairs(NUM_RANDOM);

    // Clear, then accumulation starts again from zero
    clearAll();
    checkState();
    randomPairs(3);

    // 7.9375 squared until past the positive limit, then negative products
    clearAll();
    for (int i = 0; i < OVERFLOW_PAIRS; i++) begin
      accumulatePair(8'h7f, 8'h7f);
      if (i == LIMIT_CHECK_AT - 1) checkState();
    end
    checkState();
    repeat (4) begin
      accumulatePair(8'h81, 8'h7f);
      checkState();
    end
    clearAll();
    checkState();

    // -7.9375 is the most negative finite operand since 8'h80 is infinity
    for (int i = 0; i < OVERFLOW_PAIRS; i++) begin
      accumulatePair(8'h81, 8'h7f);
      if (i == LIMIT_CHECK_AT - 1) checkState();
    end
    checkState();
    clearAll();
    checkState();

    // Infinity sticks through later accumulates until a clear
    accumulatePair(`INF_PATTERN, 8'h23);
    checkState();
    randomPairs(3);
    clearAll();
    checkState();
    accumulatePair(8'h18, 8'hf4);
    checkState();

    // The operand register returns the last pair and control reads as zero
    busRead(REG_OPERAND, {{(`BUS_WIDTH - 2 * `OPERAND_WIDTH){1'b0}}, 8'hf4, 8'h18},
            "operand");
    busRead(REG_CONTROL, '0, "control");

    if (readsChecked != readsIssued) begin
      errorCount++;
      $display("only %0d of %0d reads were acked and compared", readsChecked, readsIssued);
    end
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+logic
logic/kulischPkg.sv
logic/kulischIf.sv
logic/kulischAccumulatorAdd.sv
logic/fixedProductToKulisch.sv
logic/kulischAccumulatorUnit.sv
logic/kulischWishboneSlave.sv
logic/kulischMacTop.sv
testbench/kulischMacTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f compile.f --top-module kulischMacTb \
    -Mdir obj_dir -o kulischMacSim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/kulischMacSim > sim.log 2>&1
simStatus=$?
cat sim.log

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qxF ">>> PASS" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
